// ==== cp0_pkg.sv ====
package cp0_pkg;

    // datapath and virtual address width
    localparam int XLEN = 32;

    // joint tlb size
    localparam int TLB_ENTRIES = 4;
    localparam int TLB_INDEX_W = 2;

    // tlb field widths
    localparam int VPN2_W = 19;
    localparam int ASID_W = 8;
    localparam int PFN_W = 20;
    localparam int PAGE_OFFSET_W = 12;

    // cp0 register numbers as seen on the wishbone address
    localparam logic [4:0] REG_INDEX = 5'd0;
    localparam logic [4:0] REG_ENTRYLO0 = 5'd2;
    localparam logic [4:0] REG_ENTRYLO1 = 5'd3;
    localparam logic [4:0] REG_PAGEMASK = 5'd5;
    localparam logic [4:0] REG_BADVADDR = 5'd8;
    localparam logic [4:0] REG_ENTRYHI = 5'd10;
    localparam logic [4:0] REG_STATUS = 5'd12;
    localparam logic [4:0] REG_CAUSE = 5'd13;
    localparam logic [4:0] REG_EPC = 5'd14;

    // status after reset, only bev (bit 22) set
    localparam logic [XLEN-1:0] STATUS_RESET = 32'h0040_0000;

    // 4 KB pages only
    localparam logic [XLEN-1:0] PAGEMASK_FIXED = 32'h0000_0000;

    // per-page attributes, same order as entrylo bits 5..1
    typedef struct packed {
        // cacheability, stored but not acted on
        logic [2:0] cache_attr;
        // write enable, clear means store faults
        logic dirty;
        logic valid;
    } page_attr_t;

    // one joint tlb entry covering an even/odd page pair
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        // and of the two entrylo g bits at write time
        logic global_bit;
        // even page
        logic [PFN_W-1:0] pfn0;
        page_attr_t attr0;
        // odd page
        logic [PFN_W-1:0] pfn1;
        page_attr_t attr1;
    } tlb_entry_t;

    typedef logic [TLB_INDEX_W-1:0] tlb_index_t;

endpackage

// ==== cp0_regs.sv ====
module cp0_regs (
    input  logic clk,
    input  logic rst,
    // wishbone classic slave
    input  logic wb_cyc_i,
    input  logic wb_stb_i,
    input  logic wb_we_i,
    input  logic [4:0] wb_adr_i,
    input  logic [cp0_pkg::XLEN-1:0] wb_dat_i,
    output logic wb_ack_o,
    output logic [cp0_pkg::XLEN-1:0] wb_dat_o,
    // interrupts and exceptions from the core
    input  logic [5:0] hw_int_i,
    input  logic exc_i,
    input  logic exc_bd_i,
    input  logic [4:0] exc_code_i,
    input  logic [cp0_pkg::XLEN-1:0] exc_pc_i,
    input  logic [cp0_pkg::XLEN-1:0] exc_badvaddr_i,
    input  logic badvaddr_we_i,
    input  logic eret_i,
    // tlb instructions
    input  logic tlbwi_i,
    input  logic tlbr_i,
    input  logic tlbp_i,
    input  logic probe_miss_i,
    input  cp0_pkg::tlb_index_t probe_index_i,
    input  cp0_pkg::tlb_entry_t tlb_rd_entry_i,
    output logic tlb_we_o,
    output cp0_pkg::tlb_index_t tlb_index_o,
    output cp0_pkg::tlb_entry_t tlb_wr_entry_o,
    output logic [cp0_pkg::ASID_W-1:0] asid_o,
    output logic [cp0_pkg::XLEN-1:0] probe_vaddr_o,
    // status to the core
    output logic [cp0_pkg::XLEN-1:0] epc_o,
    output logic exl_o,
    output logic int_enable_o,
    output logic [7:0] interrupt_flag_o
);
    import cp0_pkg::*;

    // entrylo holds pfn, c/d/v and g in bits 25..0
    localparam int LO_W = PFN_W + $bits(page_attr_t) + 1;

    // index, bit 31 is the probe failure flag
    logic index_miss;
    tlb_index_t index_val;
    logic [LO_W-1:0] entrylo0;
    logic [LO_W-1:0] entrylo1;
    logic [VPN2_W-1:0] entryhi_vpn2;
    logic [ASID_W-1:0] entryhi_asid;
    // status im, exl, ie
    logic [7:0] status_im;
    logic status_exl;
    logic status_ie;
    // cause bd, software ip, exception code
    logic cause_bd;
    logic [1:0] cause_ip_sw;
    logic [4:0] cause_code;
    logic [XLEN-1:0] epc;
    logic [XLEN-1:0] badvaddr;

    logic wb_req;
    logic wb_wr;
    logic [XLEN-1:0] rd_data;
    logic [7:0] cause_ip;

    // new transfer seen while ack is low
    assign wb_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign wb_wr = wb_req & wb_we_i;

    // hardware lines on top of the two software bits
    assign cause_ip = {hw_int_i, cause_ip_sw};

    // read mux with unimplemented bits forced to zero
    always_comb begin
        case (wb_adr_i)
            REG_INDEX: rd_data = {index_miss, {(XLEN-1-TLB_INDEX_W){1'b0}}, index_val};
            REG_ENTRYLO0: rd_data = {{(XLEN-LO_W){1'b0}}, entrylo0};
            REG_ENTRYLO1: rd_data = {{(XLEN-LO_W){1'b0}}, entrylo1};
            REG_PAGEMASK: rd_data = PAGEMASK_FIXED;
            REG_BADVADDR: rd_data = badvaddr;
            REG_ENTRYHI: rd_data = {entryhi_vpn2, 5'b0, entryhi_asid};
            // bev is fixed at its reset value
            REG_STATUS: rd_data = {9'b0, STATUS_RESET[22], 6'b0, status_im, 6'b0,
                                   status_exl, status_ie};
            REG_CAUSE: rd_data = {cause_bd, 15'b0, cause_ip, 1'b0, cause_code, 2'b0};
            REG_EPC: rd_data = epc;
            default: rd_data = '0;
        endcase
    end

    // one-cycle ack, two cycles per transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_req;
        end
    end

    // read data captured on the ack edge
    always_ff @(posedge clk) begin
        if (wb_req) begin
            wb_dat_o <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            index_miss <= 1'b0;
            index_val <= '0;
            entrylo0 <= '0;
            entrylo1 <= '0;
            entryhi_vpn2 <= '0;
            entryhi_asid <= '0;
            status_im <= STATUS_RESET[15:8];
            status_exl <= STATUS_RESET[1];
            status_ie <= STATUS_RESET[0];
            cause_bd <= 1'b0;
            cause_ip_sw <= 2'b0;
            cause_code <= '0;
            epc <= '0;
            badvaddr <= '0;
        end else begin
            // mtc0 path, unknown numbers ignored
            if (wb_wr) begin
                case (wb_adr_i)
                    REG_INDEX: index_val <= wb_dat_i[TLB_INDEX_W-1:0];
                    REG_ENTRYLO0: entrylo0 <= wb_dat_i[LO_W-1:0];
                    REG_ENTRYLO1: entrylo1 <= wb_dat_i[LO_W-1:0];
                    REG_ENTRYHI: begin
                        entryhi_vpn2 <= wb_dat_i[XLEN-1 -: VPN2_W];
                        entryhi_asid <= wb_dat_i[ASID_W-1:0];
                    end
                    REG_STATUS: begin
                        status_im <= wb_dat_i[15:8];
                        status_exl <= wb_dat_i[1];
                        status_ie <= wb_dat_i[0];
                    end
                    // only the software ip bits
                    REG_CAUSE: cause_ip_sw <= wb_dat_i[9:8];
                    REG_EPC: epc <= wb_dat_i;
                    default: ;
                endcase
            end
            // tlbr, g copied into both entrylo registers
            if (tlbr_i) begin
                entryhi_vpn2 <= tlb_rd_entry_i.vpn2;
                entryhi_asid <= tlb_rd_entry_i.asid;
                entrylo0 <= {tlb_rd_entry_i.pfn0, tlb_rd_entry_i.attr0,
                             tlb_rd_entry_i.global_bit};
                entrylo1 <= {tlb_rd_entry_i.pfn1, tlb_rd_entry_i.attr1,
                             tlb_rd_entry_i.global_bit};
            end
            // tlbp result into index
            if (tlbp_i) begin
                index_miss <= probe_miss_i;
                index_val <= probe_index_i;
            end
            // exception entry takes priority over eret
            if (exc_i) begin
                epc <= exc_pc_i;
                cause_bd <= exc_bd_i;
                cause_code <= exc_code_i;
                status_exl <= 1'b1;
                entryhi_vpn2 <= exc_badvaddr_i[XLEN-1 -: VPN2_W];
                if (badvaddr_we_i) begin
                    badvaddr <= exc_badvaddr_i;
                end
            end else if (eret_i) begin
                status_exl <= 1'b0;
            end
        end
    end

    // tlbwi write port built from index, entryhi and entrylo
    assign tlb_we_o = tlbwi_i;
    assign tlb_index_o = index_val;
    assign tlb_wr_entry_o.vpn2 = entryhi_vpn2;
    assign tlb_wr_entry_o.asid = entryhi_asid;
    assign tlb_wr_entry_o.global_bit = entrylo0[0] & entrylo1[0];
    assign tlb_wr_entry_o.pfn0 = entrylo0[LO_W-1 -: PFN_W];
    assign tlb_wr_entry_o.attr0 = entrylo0[$bits(page_attr_t):1];
    assign tlb_wr_entry_o.pfn1 = entrylo1[LO_W-1 -: PFN_W];
    assign tlb_wr_entry_o.attr1 = entrylo1[$bits(page_attr_t):1];

    // current asid for all lookups
    assign asid_o = entryhi_asid;
    // probe always looks at the even page of entryhi vpn2
    assign probe_vaddr_o = {entryhi_vpn2, {(XLEN-VPN2_W){1'b0}}};

    assign epc_o = epc;
    assign exl_o = status_exl;
    // masked pending interrupts
    assign interrupt_flag_o = status_im & cause_ip;
    // no interrupt taken in the cycle an exception enters
    assign int_enable_o = status_ie & ~status_exl & ~exc_i;

endmodule

// ==== cp0_top.f ====
+incdir+.
cp0_pkg.sv
tlb_lookup.sv
tlb_array.sv
cp0_regs.sv
cp0_top.sv
tb_cp0_top.sv

// ==== cp0_top.sv ====
module cp0_top (
    input  logic clk,
    input  logic rst,
    // register access
    input  logic wb_cyc_i,
    input  logic wb_stb_i,
    input  logic wb_we_i,
    input  logic [4:0] wb_adr_i,
    input  logic [cp0_pkg::XLEN-1:0] wb_dat_i,
    output logic wb_ack_o,
    output logic [cp0_pkg::XLEN-1:0] wb_dat_o,
    // core pulses and exception info
    input  logic [5:0] hw_int_i,
    input  logic exc_i,
    input  logic exc_bd_i,
    input  logic [4:0] exc_code_i,
    input  logic [cp0_pkg::XLEN-1:0] exc_pc_i,
    input  logic [cp0_pkg::XLEN-1:0] exc_badvaddr_i,
    input  logic badvaddr_we_i,
    input  logic eret_i,
    input  logic tlbwi_i,
    input  logic tlbr_i,
    input  logic tlbp_i,
    // translation requests
    input  logic [cp0_pkg::XLEN-1:0] inst_vaddr_i,
    input  logic [cp0_pkg::XLEN-1:0] data_vaddr_i,
    output logic [cp0_pkg::XLEN-1:0] inst_paddr_o,
    output logic [cp0_pkg::XLEN-1:0] data_paddr_o,
    output logic inst_miss_o,
    output logic inst_invalid_o,
    output logic data_miss_o,
    output logic data_invalid_o,
    output logic data_dirty_fault_o,
    // status to the core
    output logic [cp0_pkg::XLEN-1:0] epc_o,
    output logic exl_o,
    output logic int_enable_o,
    output logic [7:0] interrupt_flag_o
);
    import cp0_pkg::*;

    // tlb write and read paths
    logic tlb_we;
    tlb_index_t tlb_index;
    tlb_entry_t tlb_wr_entry;
    tlb_entry_t tlb_rd_entry;
    tlb_entry_t tlb_entries [TLB_ENTRIES];

    // lookup context and probe result
    logic [ASID_W-1:0] asid;
    logic [XLEN-1:0] probe_vaddr;
    logic probe_miss;
    tlb_index_t probe_index;

    cp0_regs regs_i (
        .clk(clk),
        .rst(rst),
        .wb_cyc_i(wb_cyc_i),
        .wb_stb_i(wb_stb_i),
        .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i),
        .wb_dat_i(wb_dat_i),
        .wb_ack_o(wb_ack_o),
        .wb_dat_o(wb_dat_o),
        .hw_int_i(hw_int_i),
        .exc_i(exc_i),
        .exc_bd_i(exc_bd_i),
        .exc_code_i(exc_code_i),
        .exc_pc_i(exc_pc_i),
        .exc_badvaddr_i(exc_badvaddr_i),
        .badvaddr_we_i(badvaddr_we_i),
        .eret_i(eret_i),
        .tlbwi_i(tlbwi_i),
        .tlbr_i(tlbr_i),
        .tlbp_i(tlbp_i),
        .probe_miss_i(probe_miss),
        .probe_index_i(probe_index),
        .tlb_rd_entry_i(tlb_rd_entry),
        .tlb_we_o(tlb_we),
        .tlb_index_o(tlb_index),
        .tlb_wr_entry_o(tlb_wr_entry),
        .asid_o(asid),
        .probe_vaddr_o(probe_vaddr),
        .epc_o(epc_o),
        .exl_o(exl_o),
        .int_enable_o(int_enable_o),
        .interrupt_flag_o(interrupt_flag_o)
    );

    tlb_array array_i (
        .clk(clk),
        .rst(rst),
        .we_i(tlb_we),
        .index_i(tlb_index),
        .entry_i(tlb_wr_entry),
        .entries_o(tlb_entries),
        .rd_entry_o(tlb_rd_entry)
    );

    // fetch side, no store so no dirty fault
    tlb_lookup inst_lookup (
        .entries_i(tlb_entries),
        .vaddr_i(inst_vaddr_i),
        .asid_i(asid),
        .paddr_o(inst_paddr_o),
        .hit_index_o(),
        .miss_o(inst_miss_o),
        .invalid_o(inst_invalid_o),
        .dirty_fault_o()
    );

    tlb_lookup data_lookup (
        .entries_i(tlb_entries),
        .vaddr_i(data_vaddr_i),
        .asid_i(asid),
        .paddr_o(data_paddr_o),
        .hit_index_o(),
        .miss_o(data_miss_o),
        .invalid_o(data_invalid_o),
        .dirty_fault_o(data_dirty_fault_o)
    );

    // tlbp, only miss and hit index are used
    tlb_lookup probe_lookup (
        .entries_i(tlb_entries),
        .vaddr_i(probe_vaddr),
        .asid_i(asid),
        .paddr_o(),
        .hit_index_o(probe_index),
        .miss_o(probe_miss),
        .invalid_o(),
        .dirty_fault_o()
    );

endmodule

// ==== cp0_tb_model.svh ====
`ifndef CP0_TB_MODEL_SVH
`define CP0_TB_MODEL_SVH

// shadow copy of the implemented register fields
logic m_index_miss;
logic [1:0] m_index;
logic [25:0] m_lo0;
logic [25:0] m_lo1;
logic [18:0] m_vpn2;
logic [7:0] m_asid;
logic [7:0] m_im;
logic m_exl;
logic m_ie;
logic m_bd;
logic [1:0] m_ip_sw;
logic [4:0] m_code;
logic [31:0] m_epc;
logic [31:0] m_badvaddr;
// shadow tlb with page fields holding pfn, c, d and v but no g
logic [18:0] m_e_vpn2 [4];
logic [7:0] m_e_asid [4];
logic m_e_g [4];
logic [24:0] m_e_pg0 [4];
logic [24:0] m_e_pg1 [4];

// back to the state after reset
function automatic void clear_shadow();
    m_index_miss = 1'b0;
    m_index = '0;
    m_lo0 = '0;
    m_lo1 = '0;
    m_vpn2 = '0;
    m_asid = '0;
    m_im = '0;
    m_exl = 1'b0;
    m_ie = 1'b0;
    m_bd = 1'b0;
    m_ip_sw = '0;
    m_code = '0;
    m_epc = '0;
    m_badvaddr = '0;
    for (int i = 0; i < 4; i++) begin
        m_e_vpn2[i] = '0;
        m_e_asid[i] = '0;
        m_e_g[i] = 1'b0;
        m_e_pg0[i] = '0;
        m_e_pg1[i] = '0;
    end
endfunction

// expected read data with unimplemented bits at zero
function automatic logic [31:0] expected_read(input logic [4:0] adr);
    case (adr)
        REG_INDEX: return {m_index_miss, 29'b0, m_index};
        REG_ENTRYLO0: return {6'b0, m_lo0};
        REG_ENTRYLO1: return {6'b0, m_lo1};
        REG_BADVADDR: return m_badvaddr;
        REG_ENTRYHI: return {m_vpn2, 5'b0, m_asid};
        // bev always reads one
        REG_STATUS: return {9'b0, 1'b1, 6'b0, m_im, 6'b0, m_exl, m_ie};
        // hardware ip bits follow the input lines
        REG_CAUSE: return {m_bd, 15'b0, hw_int, m_ip_sw, 1'b0, m_code, 2'b0};
        REG_EPC: return m_epc;
        default: return 32'h0;
    endcase
endfunction

// only the writable fields change
function automatic void apply_write(input logic [4:0] adr, input logic [31:0] dat);
    case (adr)
        REG_INDEX: m_index = dat[1:0];
        REG_ENTRYLO0: m_lo0 = dat[25:0];
        REG_ENTRYLO1: m_lo1 = dat[25:0];
        REG_ENTRYHI: begin
            m_vpn2 = dat[31:13];
            m_asid = dat[7:0];
        end
        REG_STATUS: begin
            m_im = dat[15:8];
            m_exl = dat[1];
            m_ie = dat[0];
        end
        REG_CAUSE: m_ip_sw = dat[9:8];
        REG_EPC: m_epc = dat;
        default: ;
    endcase
endfunction

// tlbwi into the slot named by index
function automatic void write_shadow_entry();
    m_e_vpn2[m_index] = m_vpn2;
    m_e_asid[m_index] = m_asid;
    m_e_g[m_index] = m_lo0[0] & m_lo1[0];
    m_e_pg0[m_index] = m_lo0[25:1];
    m_e_pg1[m_index] = m_lo1[25:1];
endfunction

// tlbr back into entryhi and both entrylo
function automatic void read_shadow_entry();
    m_vpn2 = m_e_vpn2[m_index];
    m_asid = m_e_asid[m_index];
    m_lo0 = {m_e_pg0[m_index], m_e_g[m_index]};
    m_lo1 = {m_e_pg1[m_index], m_e_g[m_index]};
endfunction

// upward scan so the first match is the lowest index
function automatic logic lowest_hit(input logic [31:0] vaddr, output logic [1:0] idx);
    logic found;
    found = 1'b0;
    idx = 2'd0;
    for (int i = 0; i < 4; i++) begin
        if (!found && m_e_vpn2[i] == vaddr[31:13] && (m_e_asid[i] == m_asid || m_e_g[i])) begin
            found = 1'b1;
            idx = 2'(i);
        end
    end
    return found;
endfunction

// probe uses entryhi vpn2 with the even page
function automatic logic probe_shadow();
    logic [1:0] idx;
    logic hit;
    hit = lowest_hit({m_vpn2, 13'b0}, idx);
    m_index_miss = ~hit;
    if (hit) begin
        m_index = idx;
    end
    return hit;
endfunction

task automatic predict_translation(input logic [31:0] vaddr, output logic [31:0] paddr,
                                   output logic miss, output logic inv, output logic dirty);
    logic [1:0] idx;
    logic hit;
    logic [24:0] pg;
    hit = lowest_hit(vaddr, idx);
    // bit 12 picks the odd page
    pg = vaddr[12] ? m_e_pg1[idx] : m_e_pg0[idx];
    paddr = {pg[24:5], vaddr[11:0]};
    miss = ~hit;
    inv = hit & ~pg[0];
    dirty = hit & pg[0] & ~pg[1];
endtask

// exception entry into epc, cause, entryhi and maybe badvaddr
function automatic void enter_exception(input logic bd, input logic [4:0] code,
                                        input logic [31:0] pc, input logic [31:0] bad,
                                        input logic bad_we);
    m_epc = pc;
    m_bd = bd;
    m_code = code;
    m_exl = 1'b1;
    m_vpn2 = bad[31:13];
    if (bad_we) begin
        m_badvaddr = bad;
    end
endfunction

`endif

// ==== tb_cp0_top.sv ====
module tb_cp0_top;
    import cp0_pkg::*;

    localparam int N_ROUNDS = 8;
    localparam int N_LOOKUPS = 16;
    localparam int N_PROBES = 10;
    localparam int N_EXCS = 10;
    localparam int N_INTS = 10;
    // bus transfers, pulses and lookups over all tests
    localparam int NUM_OPS = 85 + N_ROUNDS * (21 + N_LOOKUPS) + N_PROBES * 9 +
                             N_EXCS * 6 + N_INTS * 8;
    localparam int CYCLE_LIMIT = NUM_OPS * 4 + 200;

    logic clk;
    logic rst;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [4:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic wb_ack;
    logic [31:0] wb_dat_r;
    logic [5:0] hw_int;
    logic exc;
    logic exc_bd;
    logic [4:0] exc_code;
    logic [31:0] exc_pc;
    logic [31:0] exc_badvaddr;
    logic badvaddr_we;
    logic eret;
    logic tlbwi;
    logic tlbr;
    logic tlbp;
    logic [31:0] inst_vaddr;
    logic [31:0] data_vaddr;
    logic [31:0] inst_paddr;
    logic [31:0] data_paddr;
    logic inst_miss;
    logic inst_invalid;
    logic data_miss;
    logic data_invalid;
    logic data_dirty;
    logic [31:0] epc;
    logic exl;
    logic int_enable;
    logic [7:0] int_flag;

    integer seed;
    int cycles = 0;
    // small pools so lookups mostly hit written entries
    logic [18:0] vpn_pool [6];
    logic [7:0] asid_pool [2];
    logic [31:0] rd;
    logic [31:0] d;
    logic [31:0] exp_paddr;
    logic exp_miss;
    logic exp_inv;
    logic exp_dirty;
    logic hit;

    `include "cp0_tb_model.svh"

    cp0_top cp0_top_i (
        .clk(clk), .rst(rst),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
        .wb_dat_i(wb_dat_w), .wb_ack_o(wb_ack), .wb_dat_o(wb_dat_r),
        .hw_int_i(hw_int), .exc_i(exc), .exc_bd_i(exc_bd), .exc_code_i(exc_code),
        .exc_pc_i(exc_pc), .exc_badvaddr_i(exc_badvaddr), .badvaddr_we_i(badvaddr_we),
        .eret_i(eret), .tlbwi_i(tlbwi), .tlbr_i(tlbr), .tlbp_i(tlbp),
        .inst_vaddr_i(inst_vaddr), .data_vaddr_i(data_vaddr),
        .inst_paddr_o(inst_paddr), .data_paddr_o(data_paddr),
        .inst_miss_o(inst_miss), .inst_invalid_o(inst_invalid),
        .data_miss_o(data_miss), .data_invalid_o(data_invalid),
        .data_dirty_fault_o(data_dirty),
        .epc_o(epc), .exl_o(exl), .int_enable_o(int_enable), .interrupt_flag_o(int_flag)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles before all tests finished", cycles);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // one wishbone classic transfer with a single-cycle ack
    task automatic wb_xfer(input logic we, input logic [4:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdata);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr;
        wb_dat_w <= dat;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        rdata = wb_dat_r;
        if (we) begin
            apply_write(adr, dat);
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
        @(negedge clk);
        check({31'b0, wb_ack}, 32'd0, "ack high for more than one cycle");
    endtask

    task automatic wb_write(input logic [4:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_xfer(1'b1, adr, dat, unused);
    endtask

    task automatic read_and_compare(input logic [4:0] adr);
        logic [31:0] rdata;
        wb_xfer(1'b0, adr, 32'h0, rdata);
        check(rdata, expected_read(adr), $sformatf("read of register %0d", adr));
    endtask

    // mask order is tlbwi, tlbr, tlbp, exc, eret
    task automatic core_pulse(input logic [4:0] mask);
        @(posedge clk);
        tlbwi <= mask[4];
        tlbr <= mask[3];
        tlbp <= mask[2];
        exc <= mask[1];
        eret <= mask[0];
        @(negedge clk);
        if (mask[1]) begin
            check({31'b0, int_enable}, 32'd0, "int_enable_o high while exc_i is high");
        end
        @(posedge clk);
        tlbwi <= 1'b0;
        tlbr <= 1'b0;
        tlbp <= 1'b0;
        exc <= 1'b0;
        eret <= 1'b0;
    endtask

    // random exception with an optional eret in the same cycle
    task automatic raise_exception(input logic with_eret);
        logic [31:0] r;
        logic [31:0] pc;
        logic [31:0] bad;
        r = $random(seed);
        pc = $random(seed);
        bad = $random(seed);
        @(posedge clk);
        exc_bd <= r[0];
        exc_code <= r[5:1];
        exc_pc <= pc;
        exc_badvaddr <= bad;
        badvaddr_we <= r[6];
        core_pulse({3'b000, 1'b1, with_eret});
        enter_exception(r[0], r[5:1], pc, bad, r[6]);
    endtask

    function automatic logic [31:0] rand_vaddr();
        logic [31:0] r;
        r = $random(seed);
        // one in eight is a fully random address
        if (r[31:29] != 3'd0) begin
            r[31:13] = vpn_pool[3'($unsigned($random(seed)) % 6)];
        end
        return r;
    endfunction

    initial begin
        seed = 32'h421f;
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        hw_int = '0;
        exc = 1'b0;
        exc_bd = 1'b0;
        exc_code = '0;
        exc_pc = '0;
        exc_badvaddr = '0;
        badvaddr_we = 1'b0;
        eret = 1'b0;
        tlbwi = 1'b0;
        tlbr = 1'b0;
        tlbp = 1'b0;
        inst_vaddr = 32'hffff_f000;
        data_vaddr = 32'h1234_5678;
        clear_shadow();
        for (int i = 0; i < 6; i++) begin
            vpn_pool[i] = 19'($random(seed));
        end
        asid_pool[0] = 8'($random(seed));
        asid_pool[1] = asid_pool[0] ^ 8'h5a;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check({29'b0, wb_ack, int_enable, exl}, 32'd0, "ack, int_enable or exl after reset");
        check({30'b0, inst_miss, data_miss}, 32'd3, "lookups after reset should miss");

        // every register number and then random mixed traffic
        for (int a = 0; a < 32; a++) begin
            wb_write(5'(a), $random(seed));
        end
        for (int a = 0; a < 32; a++) begin
            read_and_compare(5'(a));
        end
        for (int k = 0; k < 20; k++) begin
            d = $random(seed);
            if (d[0]) begin
                wb_write(d[5:1], $random(seed));
            end else begin
                read_and_compare(d[5:1]);
            end
        end

        // tlbwi rounds followed by both lookups side by side
        for (int r = 0; r < N_ROUNDS; r++) begin
            for (int e = 0; e < 4; e++) begin
                d = $random(seed);
                d[31:13] = vpn_pool[3'($unsigned($random(seed)) % 6)];
                d[7:0] = asid_pool[d[8]];
                wb_write(REG_ENTRYHI, d);
                wb_write(REG_ENTRYLO0, $random(seed));
                wb_write(REG_ENTRYLO1, $random(seed));
                wb_write(REG_INDEX, $random(seed));
                core_pulse(5'b10000);
                write_shadow_entry();
            end
            d = $random(seed);
            d[7:0] = asid_pool[d[8]];
            wb_write(REG_ENTRYHI, d);
            for (int k = 0; k < N_LOOKUPS; k++) begin
                @(posedge clk);
                inst_vaddr <= rand_vaddr();
                data_vaddr <= rand_vaddr();
                @(negedge clk);
                predict_translation(inst_vaddr, exp_paddr, exp_miss, exp_inv, exp_dirty);
                check({30'b0, inst_miss, inst_invalid}, {30'b0, exp_miss, exp_inv},
                      "instruction miss and invalid flags");
                if (!exp_miss) begin
                    check(inst_paddr, exp_paddr, "instruction physical address");
                end
                predict_translation(data_vaddr, exp_paddr, exp_miss, exp_inv, exp_dirty);
                check({29'b0, data_miss, data_invalid, data_dirty},
                      {29'b0, exp_miss, exp_inv, exp_dirty}, "data fault flags");
                if (!exp_miss) begin
                    check(data_paddr, exp_paddr, "data physical address");
                end
            end
        end

        // tlbp with present or absent vpn2 followed by tlbr
        for (int p = 0; p < N_PROBES; p++) begin
            d = $random(seed);
            if (d[9]) begin
                d[31:13] = vpn_pool[3'($unsigned($random(seed)) % 6)];
            end
            d[7:0] = asid_pool[d[8]];
            wb_write(REG_ENTRYHI, d);
            core_pulse(5'b00100);
            hit = probe_shadow();
            wb_xfer(1'b0, REG_INDEX, 32'h0, rd);
            check({31'b0, rd[31]}, {31'b0, ~hit}, "index probe failure bit");
            if (hit) begin
                check({30'b0, rd[1:0]}, {30'b0, m_index}, "index after probe hit");
            end
            wb_write(REG_INDEX, $random(seed));
            core_pulse(5'b01000);
            read_shadow_entry();
            read_and_compare(REG_ENTRYHI);
            read_and_compare(REG_ENTRYLO0);
            read_and_compare(REG_ENTRYLO1);
        end

        // ie set and exl clear so exc_i alone must hold int_enable_o low
        d = $random(seed);
        d[1:0] = 2'b01;
        wb_write(REG_STATUS, d);

        // exception entry and return
        for (int x = 0; x < N_EXCS; x++) begin
            d = $random(seed);
            raise_exception(d[2:0] == 3'd0);
            @(negedge clk);
            check({31'b0, exl}, 32'd1, "exl after exception");
            check(epc, m_epc, "epc output after exception");
            read_and_compare(REG_EPC);
            read_and_compare(REG_CAUSE);
            read_and_compare(REG_BADVADDR);
            read_and_compare(REG_ENTRYHI);
            core_pulse(5'b00001);
            m_exl = 1'b0;
            @(negedge clk);
            check({31'b0, exl}, 32'd0, "exl after eret");
        end

        // interrupt mask and enable
        for (int q = 0; q < N_INTS; q++) begin
            @(posedge clk);
            hw_int <= 6'($random(seed));
            wb_write(REG_STATUS, $random(seed));
            wb_write(REG_CAUSE, $random(seed));
            @(negedge clk);
            check({24'b0, int_flag}, {24'b0, m_im & {hw_int, m_ip_sw}}, "interrupt flags");
            check({31'b0, int_enable}, {31'b0, m_ie & ~m_exl}, "interrupt enable");
            read_and_compare(REG_CAUSE);
            raise_exception(1'b0);
            core_pulse(5'b00001);
            m_exl = 1'b0;
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== tlb_array.sv ====
module tlb_array (
    input  logic clk,
    input  logic rst,
    input  logic we_i,
    input  cp0_pkg::tlb_index_t index_i,
    input  cp0_pkg::tlb_entry_t entry_i,
    output cp0_pkg::tlb_entry_t entries_o [cp0_pkg::TLB_ENTRIES],
    output cp0_pkg::tlb_entry_t rd_entry_o
);
    import cp0_pkg::*;

    // entry storage, shared by all three lookups
    tlb_entry_t entry_q [TLB_ENTRIES];

    // all entries cleared on reset so nothing hits
    // outside vpn2 zero until software writes the tlb
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entry_q[i] <= '0;
            end
        end else if (we_i) begin
            // tlbwi, slot chosen by the index register
            entry_q[index_i] <= entry_i;
        end
    end

    // full array out to the lookups
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            entries_o[i] = entry_q[i];
        end
    end

    // indexed read for tlbr
    assign rd_entry_o = entry_q[index_i];

endmodule

// ==== tlb_lookup.sv ====
module tlb_lookup (
    input  cp0_pkg::tlb_entry_t entries_i [cp0_pkg::TLB_ENTRIES],
    input  logic [cp0_pkg::XLEN-1:0] vaddr_i,
    input  logic [cp0_pkg::ASID_W-1:0] asid_i,
    output logic [cp0_pkg::XLEN-1:0] paddr_o,
    output cp0_pkg::tlb_index_t hit_index_o,
    output logic miss_o,
    output logic invalid_o,
    output logic dirty_fault_o
);
    import cp0_pkg::*;

    // one bit per entry, set on vpn2 and asid/global match
    logic [TLB_ENTRIES-1:0] hit_vec;
    tlb_index_t hit_idx;
    tlb_entry_t sel_entry;
    // bit 12 picks the odd page of the pair
    logic odd_page;
    logic [PFN_W-1:0] sel_pfn;
    page_attr_t sel_attr;
    logic any_hit;

    // parallel compare against every entry
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hit_vec[i] = (entries_i[i].vpn2 == vaddr_i[XLEN-1 -: VPN2_W]) &&
                         ((entries_i[i].asid == asid_i) || entries_i[i].global_bit);
        end
    end

    // priority encoder, lowest index wins on multiple hits
    // scan downward so the last assignment is the lowest hit
    always_comb begin
        hit_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_idx = tlb_index_t'(i);
            end
        end
    end

    assign any_hit = |hit_vec;

    // entry 0 is selected on a miss, flags below mask it
    assign sel_entry = entries_i[hit_idx];
    assign odd_page = vaddr_i[PAGE_OFFSET_W];

    // even/odd page select
    always_comb begin
        if (odd_page) begin
            sel_pfn = sel_entry.pfn1;
            sel_attr = sel_entry.attr1;
        end else begin
            sel_pfn = sel_entry.pfn0;
            sel_attr = sel_entry.attr0;
        end
    end

    // pfn followed by the untranslated page offset
    assign paddr_o = {sel_pfn, vaddr_i[PAGE_OFFSET_W-1:0]};
    assign hit_index_o = hit_idx;

    // fault flags
    assign miss_o = ~any_hit;
    assign invalid_o = any_hit & ~sel_attr.valid;
    // core qualifies this with store
    assign dirty_fault_o = any_hit & sel_attr.valid & ~sel_attr.dirty;

endmodule
